/* design/payload_fifo.sv */
`default_nettype none

module payload_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input wire logic   i_clk,
    input wire logic   i_rst,
    udp_stream_if.sink   s_in,
    udp_stream_if.source m_out
);
    import udp_pkg::*;

    localparam int         AW         = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

    // each entry holds {last, data}
    logic [8:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign s_in.ready  = (count != FULL_COUNT);
    assign m_out.valid = (count != '0);
    assign m_out.data  = byte_t'(mem[rd_ptr][7:0]);
    assign m_out.last  = mem[rd_ptr][8];

    assign wr_en = s_in.valid && s_in.ready;
    assign rd_en = m_out.valid && m_out.ready;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {s_in.last, s_in.data};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overfill: assert property (
        @(posedge i_clk) disable iff (i_rst)
        count <= FULL_COUNT
    );

    // pointers only coincide with data present when completely full
    a_valid_not_empty: assert property (
        @(posedge i_clk) disable iff (i_rst)
        m_out.valid |-> (rd_ptr != wr_ptr || count == FULL_COUNT)
    );

endmodule

`default_nettype wire

/* design/status_display.sv */
`default_nettype none

module status_display #(
    parameter udp_pkg::ipv4_t DEST_IP = {8'd192, 8'd168, 8'd50, 8'd82}
) (
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire logic      i_hdr_accepted,
    udp_stream_if.monitor  mon,
    output udp_pkg::byte_t o_led,
    output udp_pkg::seg7_t o_hex [8]
);
    import udp_pkg::*;

    logic  in_frame;
    logic  mon_xfer;
    ipv4_t ip_q;

    // active-low hex digit patterns
    function automatic seg7_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'h40;
            4'h1:    return 7'h79;
            4'h2:    return 7'h24;
            4'h3:    return 7'h30;
            4'h4:    return 7'h19;
            4'h5:    return 7'h12;
            4'h6:    return 7'h02;
            4'h7:    return 7'h78;
            4'h8:    return 7'h00;
            4'h9:    return 7'h10;
            4'hA:    return 7'h08;
            4'hB:    return 7'h03;
            4'hC:    return 7'h46;
            4'hD:    return 7'h21;
            4'hE:    return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    assign mon_xfer = mon.valid && mon.ready;

    // first byte of each datagram goes to the leds
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_frame <= 1'b0;
            o_led    <= '0;
        end else if (mon_xfer) begin
            if (!in_frame) begin
                o_led <= mon.data;
            end
            in_frame <= !mon.last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ip_q <= '0;
        end else if (i_hdr_accepted) begin
            ip_q <= DEST_IP;
        end
    end

    // digit k shows nibble k
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            o_hex[k] = hex_to_seg(ip_q[4*k +: 4]);
        end
    end

endmodule

`default_nettype wire

/* design/udp_endpoint.sv */
`default_nettype none

module udp_endpoint #(
    parameter udp_pkg::port_t LOCAL_PORT = 16'd1234,
    parameter udp_pkg::port_t DEST_PORT  = 16'd8080,
    parameter udp_pkg::ipv4_t DEST_IP    = {8'd192, 8'd168, 8'd50, 8'd82},
    parameter int             FIFO_DEPTH = 16
) (
    input  wire logic           i_clk,
    input  wire logic           i_rst,
    // receive side
    input  wire udp_pkg::byte_t i_in_data,
    input  wire logic           i_in_valid,
    output logic                o_in_ready,
    input  wire logic           i_in_last,
    output udp_pkg::byte_t      o_rx_data,
    output logic                o_rx_valid,
    input  wire logic           i_rx_ready,
    output logic                o_rx_last,
    output udp_pkg::byte_t      o_led,
    // transmit side
    input  wire logic           i_tx_hdr_valid,
    output logic                o_tx_hdr_ready,
    input  wire udp_pkg::len_t  i_tx_length,
    input  wire udp_pkg::byte_t i_tx_data,
    input  wire logic           i_tx_valid,
    output logic                o_tx_ready,
    input  wire logic           i_tx_last,
    output udp_pkg::byte_t      o_out_data,
    output logic                o_out_valid,
    input  wire logic           i_out_ready,
    output logic                o_out_last,
    // seven-segment digits, digit 0 is the low nibble
    output udp_pkg::seg7_t      o_hex0,
    output udp_pkg::seg7_t      o_hex1,
    output udp_pkg::seg7_t      o_hex2,
    output udp_pkg::seg7_t      o_hex3,
    output udp_pkg::seg7_t      o_hex4,
    output udp_pkg::seg7_t      o_hex5,
    output udp_pkg::seg7_t      o_hex6,
    output udp_pkg::seg7_t      o_hex7
);
    import udp_pkg::*;

    seg7_t hex_w [8];
    logic  hdr_accepted;

    udp_stream_if filt_if ();
    udp_stream_if rx_out_if ();

    assign rx_out_if.ready = i_rx_ready;
    assign o_rx_data       = rx_out_if.data;
    assign o_rx_valid      = rx_out_if.valid;
    assign o_rx_last       = rx_out_if.last;

    udp_rx_filter #(
        .LOCAL_PORT(LOCAL_PORT)
    ) rx_filter_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_in_data (i_in_data),
        .i_in_valid(i_in_valid),
        .o_in_ready(o_in_ready),
        .i_in_last (i_in_last),
        .m_out     (filt_if.source)
    );

    payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rx_fifo_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .s_in (filt_if.sink),
        .m_out(rx_out_if.source)
    );

    udp_tx_framer #(
        .LOCAL_PORT(LOCAL_PORT),
        .DEST_PORT (DEST_PORT)
    ) tx_framer_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_tx_hdr_valid(i_tx_hdr_valid),
        .o_tx_hdr_ready(o_tx_hdr_ready),
        .i_tx_length   (i_tx_length),
        .i_tx_data     (i_tx_data),
        .i_tx_valid    (i_tx_valid),
        .o_tx_ready    (o_tx_ready),
        .i_tx_last     (i_tx_last),
        .o_out_data    (o_out_data),
        .o_out_valid   (o_out_valid),
        .i_out_ready   (i_out_ready),
        .o_out_last    (o_out_last),
        .o_hdr_accepted(hdr_accepted)
    );

    status_display #(
        .DEST_IP(DEST_IP)
    ) status_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_hdr_accepted(hdr_accepted),
        .mon           (rx_out_if.monitor),
        .o_led         (o_led),
        .o_hex         (hex_w)
    );

    assign o_hex0 = hex_w[0];
    assign o_hex1 = hex_w[1];
    assign o_hex2 = hex_w[2];
    assign o_hex3 = hex_w[3];
    assign o_hex4 = hex_w[4];
    assign o_hex5 = hex_w[5];
    assign o_hex6 = hex_w[6];
    assign o_hex7 = hex_w[7];

endmodule

`default_nettype wire

/* design/udp_pkg.sv */
`default_nettype none

package udp_pkg;

    // stream and header field types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;

    // first octet sits in the top byte
    typedef logic [31:0] ipv4_t;

    // bit 0 is segment a, bit 6 is segment g, active low
    typedef logic [6:0]  seg7_t;

    // udp header layout, big-endian fields
    localparam int UDP_HDR_BYTES = 8;
    localparam int HDR_DPORT_HI  = 2;
    localparam int HDR_DPORT_LO  = 3;

    // receive filter states
    typedef enum logic [1:0] {
        RX_HDR,
        RX_PASS,
        RX_DROP
    } rx_state_e;

    // transmit framer states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_PAY
    } tx_state_e;

endpackage

`default_nettype wire

/* design/udp_rx_filter.sv */
`default_nettype none

module udp_rx_filter #(
    parameter udp_pkg::port_t LOCAL_PORT = 16'd1234
) (
    input  wire logic           i_clk,
    input  wire logic           i_rst,
    input  wire udp_pkg::byte_t i_in_data,
    input  wire logic           i_in_valid,
    output logic                o_in_ready,
    input  wire logic           i_in_last,
    udp_stream_if.source        m_out
);
    import udp_pkg::*;

    localparam logic [2:0] LAST_HDR_IDX = 3'(UDP_HDR_BYTES - 1);

    rx_state_e  state;
    logic [2:0] hdr_cnt;
    port_t      dport_q;
    logic       in_xfer;

    // header and drop phases never stall the input
    assign o_in_ready = (state == RX_PASS) ? m_out.ready : 1'b1;
    assign in_xfer    = i_in_valid && o_in_ready;

    // payload goes straight through while passing
    assign m_out.data  = i_in_data;
    assign m_out.last  = i_in_last;
    assign m_out.valid = (state == RX_PASS) && i_in_valid;

    // destination port is bytes 2 and 3 of the header
    always_ff @(posedge i_clk) begin
        if (state == RX_HDR && in_xfer) begin
            if (hdr_cnt == 3'(HDR_DPORT_HI)) begin
                dport_q[15:8] <= i_in_data;
            end
            if (hdr_cnt == 3'(HDR_DPORT_LO)) begin
                dport_q[7:0] <= i_in_data;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= RX_HDR;
            hdr_cnt <= '0;
        end else if (in_xfer) begin
            case (state)
                RX_HDR: begin
                    if (i_in_last) begin
                        // short datagram is thrown away
                        hdr_cnt <= '0;
                    end else if (hdr_cnt == LAST_HDR_IDX) begin
                        hdr_cnt <= '0;
                        state   <= (dport_q == LOCAL_PORT) ? RX_PASS : RX_DROP;
                    end else begin
                        hdr_cnt <= hdr_cnt + 3'd1;
                    end
                end
                RX_PASS, RX_DROP: begin
                    if (i_in_last) begin
                        state <= RX_HDR;
                    end
                end
                default: state <= RX_HDR;
            endcase
        end
    end

    // forwarded payload only follows a header that carried the local port
    a_valid_only_in_pass: assert property (
        @(posedge i_clk) disable iff (i_rst)
        m_out.valid |-> (hdr_cnt == '0 && dport_q == LOCAL_PORT)
    );

endmodule

`default_nettype wire

/* design/udp_stream_if.sv */
`default_nettype none

interface udp_stream_if;
    import udp_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;

    modport source (
        output data, valid, last,
        input  ready
    );

    modport sink (
        input  data, valid, last,
        output ready
    );

    // passive tap, e.g. for status logic
    modport monitor (
        input data, valid, ready, last
    );

endinterface

`default_nettype wire

/* design/udp_tx_framer.sv */
`default_nettype none

module udp_tx_framer #(
    parameter udp_pkg::port_t LOCAL_PORT = 16'd1234,
    parameter udp_pkg::port_t DEST_PORT  = 16'd8080
) (
    input  wire logic           i_clk,
    input  wire logic           i_rst,
    input  wire logic           i_tx_hdr_valid,
    output logic                o_tx_hdr_ready,
    input  wire udp_pkg::len_t  i_tx_length,
    input  wire udp_pkg::byte_t i_tx_data,
    input  wire logic           i_tx_valid,
    output logic                o_tx_ready,
    input  wire logic           i_tx_last,
    output udp_pkg::byte_t      o_out_data,
    output logic                o_out_valid,
    input  wire logic           i_out_ready,
    output logic                o_out_last,
    output logic                o_hdr_accepted
);
    import udp_pkg::*;

    localparam logic [2:0] LAST_HDR_IDX = 3'(UDP_HDR_BYTES - 1);

    tx_state_e  state;
    logic [2:0] byte_idx;
    len_t       len_q;
    byte_t      hdr_byte;
    logic       hdr_acc;

    assign o_tx_hdr_ready = (state == TX_IDLE);
    assign hdr_acc        = i_tx_hdr_valid && o_tx_hdr_ready;

    // header bytes, all fields big-endian, checksum left at zero
    always_comb begin
        case (byte_idx)
            3'd0:    hdr_byte = LOCAL_PORT[15:8];
            3'd1:    hdr_byte = LOCAL_PORT[7:0];
            3'd2:    hdr_byte = DEST_PORT[15:8];
            3'd3:    hdr_byte = DEST_PORT[7:0];
            3'd4:    hdr_byte = len_q[15:8];
            3'd5:    hdr_byte = len_q[7:0];
            default: hdr_byte = 8'h00;
        endcase
    end

    always_comb begin
        o_out_data  = hdr_byte;
        o_out_valid = 1'b0;
        o_out_last  = 1'b0;
        o_tx_ready  = 1'b0;
        case (state)
            TX_HDR: o_out_valid = 1'b1;
            TX_PAY: begin
                o_out_data  = i_tx_data;
                o_out_valid = i_tx_valid;
                o_out_last  = i_tx_last;
                o_tx_ready  = i_out_ready;
            end
            default: ;
        endcase
    end

    // udp length covers header plus payload
    always_ff @(posedge i_clk) begin
        if (hdr_acc) begin
            len_q <= len_t'(i_tx_length + len_t'(UDP_HDR_BYTES));
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state          <= TX_IDLE;
            byte_idx       <= '0;
            o_hdr_accepted <= 1'b0;
        end else begin
            o_hdr_accepted <= hdr_acc;
            case (state)
                TX_IDLE: begin
                    if (hdr_acc) begin
                        state    <= TX_HDR;
                        byte_idx <= '0;
                    end
                end
                TX_HDR: begin
                    if (i_out_ready) begin
                        byte_idx <= byte_idx + 3'd1;
                        if (byte_idx == LAST_HDR_IDX) begin
                            // empty datagram has nothing to forward
                            state <= (len_q == len_t'(UDP_HDR_BYTES)) ? TX_IDLE : TX_PAY;
                        end
                    end
                end
                TX_PAY: begin
                    if (i_tx_valid && i_out_ready && i_tx_last) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // held output must not change until the sink takes it
    a_out_stable: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data))
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_udp_endpoint \
    -f udp_endpoint.f -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

/* udp_endpoint.f */
design/udp_pkg.sv
design/udp_stream_if.sv
design/udp_rx_filter.sv
design/payload_fifo.sv
design/udp_tx_framer.sv
design/status_display.sv
design/udp_endpoint.sv
verif/tb_udp_endpoint.sv

/* verif/tb_udp_endpoint.sv */
`default_nettype none

module tb_udp_endpoint;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [15:0] LOCAL_PORT = 16'd1234;
    localparam logic [15:0] DEST_PORT  = 16'd8080;
    localparam logic [31:0] DEST_IP    = {8'd192, 8'd168, 8'd50, 8'd82};
    localparam int          NUM_TESTS  = 8;

    // one row per step with a receive datagram and a transmit length
    typedef struct packed {
        logic [15:0] dport;
        logic [7:0]  len;
        logic [7:0]  base;
        logic        trunc;
        logic        bp;
        logic [7:0]  tx_len;
    } dgram_t;

    localparam dgram_t TESTS [NUM_TESTS] = '{
        '{16'd1234, 8'd5,  8'h10, 1'b0, 1'b0, 8'd3},
        '{16'd4000, 8'd6,  8'h20, 1'b0, 1'b0, 8'd0},
        '{16'd1234, 8'd0,  8'h30, 1'b0, 1'b0, 8'd1},
        '{16'd1234, 8'd3,  8'h38, 1'b1, 1'b0, 8'd7},
        '{16'd1234, 8'd20, 8'h40, 1'b0, 1'b1, 8'd20},
        '{16'd1234, 8'd1,  8'hA0, 1'b0, 1'b0, 8'd2},
        '{16'd80,   8'd12, 8'h50, 1'b0, 1'b1, 8'd5},
        '{16'd1234, 8'd17, 8'hF0, 1'b0, 1'b1, 8'd12}
    };

    logic        i_clk;
    logic        i_rst;
    logic [7:0]  i_in_data;
    logic        i_in_valid;
    logic        o_in_ready;
    logic        i_in_last;
    logic [7:0]  o_rx_data;
    logic        o_rx_valid;
    logic        i_rx_ready;
    logic        o_rx_last;
    logic [7:0]  o_led;
    logic        i_tx_hdr_valid;
    logic        o_tx_hdr_ready;
    logic [15:0] i_tx_length;
    logic [7:0]  i_tx_data;
    logic        i_tx_valid;
    logic        o_tx_ready;
    logic        i_tx_last;
    logic [7:0]  o_out_data;
    logic        o_out_valid;
    logic        i_out_ready;
    logic        o_out_last;
    logic [6:0]  hex_seen [8];

    // expected entries are {last, data}
    logic [8:0]  rx_exp [$];
    logic [8:0]  tx_exp [$];
    logic [7:0]  led_exp [$];
    logic        bp_mode = 1'b0;
    logic        led_pending = 1'b0;
    logic        stall_seen = 1'b0;
    int          cycles = 0;
    int          cycle_limit = 0;

    udp_endpoint #(
        .LOCAL_PORT(LOCAL_PORT),
        .DEST_PORT (DEST_PORT),
        .DEST_IP   (DEST_IP),
        .FIFO_DEPTH(16)
    ) dut_i (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_in_data(i_in_data), .i_in_valid(i_in_valid),
        .o_in_ready(o_in_ready), .i_in_last(i_in_last),
        .o_rx_data(o_rx_data), .o_rx_valid(o_rx_valid),
        .i_rx_ready(i_rx_ready), .o_rx_last(o_rx_last), .o_led(o_led),
        .i_tx_hdr_valid(i_tx_hdr_valid), .o_tx_hdr_ready(o_tx_hdr_ready),
        .i_tx_length(i_tx_length), .i_tx_data(i_tx_data),
        .i_tx_valid(i_tx_valid), .o_tx_ready(o_tx_ready), .i_tx_last(i_tx_last),
        .o_out_data(o_out_data), .o_out_valid(o_out_valid),
        .i_out_ready(i_out_ready), .o_out_last(o_out_last),
        .o_hex0(hex_seen[0]), .o_hex1(hex_seen[1]),
        .o_hex2(hex_seen[2]), .o_hex3(hex_seen[3]),
        .o_hex4(hex_seen[4]), .o_hex5(hex_seen[5]),
        .o_hex6(hex_seen[6]), .o_hex7(hex_seen[7])
    );

    always #4 i_clk = ~i_clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf(
                "CHECK FAILED time=%0t signal=%s got=0x%0h expected=0x%0h",
                $time, name, got, exp));
        end
    endtask

    // active-high segment patterns in gfedcba order
    function automatic logic [6:0] seg_on(input logic [3:0] v);
        case (v)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic int table_bytes();
        int total;
        int k;
        total = 0;
        for (k = 0; k < NUM_TESTS; k++) begin
            total += TESTS[k].trunc ? 5 : (8 + int'(TESTS[k].len));
            total += 8 + int'(TESTS[k].tx_len);
        end
        return total;
    endfunction

    task automatic check_digits(input logic [31:0] ip);
        int         k;
        logic [6:0] want;
        for (k = 0; k < 8; k++) begin
            want = ~seg_on(ip[4*k +: 4]);
            check_value($sformatf("o_hex%0d", k), 32'(hex_seen[k]), 32'(want));
        end
    endtask

    // drive after the edge and sample ready at the falling edge
    task automatic send_in_byte(input logic [7:0] d, input logic last);
        logic took;
        i_in_data  = d;
        i_in_valid = 1'b1;
        i_in_last  = last;
        took = 1'b0;
        while (!took) begin
            @(negedge i_clk);
            took = o_in_ready;
            @(posedge i_clk);
            #1;
        end
        i_in_valid = 1'b0;
        i_in_last  = 1'b0;
    endtask

    task automatic send_tx_byte(input logic [7:0] d, input logic last);
        logic took;
        i_tx_data  = d;
        i_tx_valid = 1'b1;
        i_tx_last  = last;
        took = 1'b0;
        while (!took) begin
            @(negedge i_clk);
            took = o_tx_ready;
            @(posedge i_clk);
            #1;
        end
        i_tx_valid = 1'b0;
        i_tx_last  = 1'b0;
    endtask

    task automatic send_rx_dgram(input dgram_t t);
        logic [7:0]  hdr [8];
        logic [15:0] ulen;
        logic [8:0]  ent;
        int          nhdr;
        int          j;
        ulen   = 16'(t.len) + 16'd8;
        hdr[0] = 8'hC0;
        hdr[1] = t.base;
        hdr[2] = t.dport[15:8];
        hdr[3] = t.dport[7:0];
        hdr[4] = ulen[15:8];
        hdr[5] = ulen[7:0];
        hdr[6] = 8'h00;
        hdr[7] = 8'h00;
        nhdr = t.trunc ? 5 : 8;
        // only complete, non-empty datagrams for the local port come out
        if (!t.trunc && t.dport == LOCAL_PORT && t.len != 0) begin
            led_exp.push_back(t.base);
            for (j = 0; j < int'(t.len); j++) begin
                ent[8]   = (j == int'(t.len) - 1);
                ent[7:0] = t.base + j[7:0];
                rx_exp.push_back(ent);
            end
        end
        for (j = 0; j < nhdr; j++) begin
            send_in_byte(hdr[j], (j == nhdr - 1) && (t.trunc || t.len == 0));
        end
        if (!t.trunc) begin
            for (j = 0; j < int'(t.len); j++) begin
                send_in_byte(t.base + j[7:0], j == int'(t.len) - 1);
            end
        end
    endtask

    task automatic send_tx_dgram(input logic [7:0] n);
        logic [15:0] ulen;
        logic [8:0]  ent;
        logic        took;
        int          j;
        ulen = 16'(n) + 16'd8;
        tx_exp.push_back({1'b0, LOCAL_PORT[15:8]});
        tx_exp.push_back({1'b0, LOCAL_PORT[7:0]});
        tx_exp.push_back({1'b0, DEST_PORT[15:8]});
        tx_exp.push_back({1'b0, DEST_PORT[7:0]});
        tx_exp.push_back({1'b0, ulen[15:8]});
        tx_exp.push_back({1'b0, ulen[7:0]});
        tx_exp.push_back(9'h000);
        tx_exp.push_back(9'h000);
        for (j = 0; j < int'(n); j++) begin
            ent[8]   = (j == int'(n) - 1);
            ent[7:0] = 8'h60 + j[7:0];
            tx_exp.push_back(ent);
        end
        i_tx_hdr_valid = 1'b1;
        i_tx_length    = 16'(n);
        took = 1'b0;
        while (!took) begin
            @(negedge i_clk);
            took = o_tx_hdr_ready;
            @(posedge i_clk);
            #1;
        end
        i_tx_hdr_valid = 1'b0;
        for (j = 0; j < int'(n); j++) begin
            send_tx_byte(8'h60 + j[7:0], j == int'(n) - 1);
        end
    endtask

    // receive scoreboard with random back-pressure
    initial begin
        logic [8:0] ent;
        logic       in_frame;
        logic [7:0] cur_led;
        in_frame = 1'b0;
        cur_led  = 8'h00;
        @(negedge i_rst);
        forever begin
            @(posedge i_clk);
            #1;
            i_rx_ready = bp_mode ? ($urandom_range(15) == 0) : 1'b1;
            @(negedge i_clk);
            if (i_in_valid && !o_in_ready) begin
                stall_seen = 1'b1;
            end
            if (led_pending) begin
                check_value("o_led", 32'(o_led), 32'(cur_led));
                led_pending = 1'b0;
            end
            if (o_rx_valid && i_rx_ready) begin
                if (rx_exp.size() == 0) begin
                    stop_with_failure("receive output delivered a byte that was not expected");
                end else begin
                    ent = rx_exp.pop_front();
                    check_value("o_rx_data", 32'(o_rx_data), 32'(ent[7:0]));
                    check_value("o_rx_last", 32'(o_rx_last), 32'(ent[8]));
                    if (!in_frame) begin
                        cur_led = led_exp.pop_front();
                    end
                    in_frame = !ent[8];
                    if (ent[8]) begin
                        led_pending = 1'b1;
                    end
                end
            end
        end
    end

    // transmit scoreboard also watches header ready during a datagram
    initial begin
        logic [8:0] ent;
        int         tx_left;
        tx_left = 0;
        @(negedge i_rst);
        forever begin
            @(posedge i_clk);
            #1;
            i_out_ready = ($urandom_range(3) != 0);
            @(negedge i_clk);
            if (tx_left != 0) begin
                check_value("o_tx_hdr_ready", 32'(o_tx_hdr_ready), 32'd0);
            end
            if (o_out_valid && i_out_ready) begin
                if (tx_exp.size() == 0) begin
                    stop_with_failure("transmit output sent a byte beyond the expected datagram");
                end else begin
                    ent = tx_exp.pop_front();
                    check_value("o_out_data", 32'(o_out_data), 32'(ent[7:0]));
                    check_value("o_out_last", 32'(o_out_last), 32'(ent[8]));
                    tx_left--;
                end
            end
            if (i_tx_hdr_valid && o_tx_hdr_ready) begin
                tx_left = int'(i_tx_length) + 8;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            stop_with_failure($sformatf("timeout: tests not finished after %0d cycles", cycles));
        end
    end

    initial begin
        int idx;
        i_clk          = 1'b0;
        i_rst          = 1'b1;
        i_in_data      = 8'h00;
        i_in_valid     = 1'b0;
        i_in_last      = 1'b0;
        i_rx_ready     = 1'b1;
        i_tx_hdr_valid = 1'b0;
        i_tx_length    = 16'd0;
        i_tx_data      = 8'h00;
        i_tx_valid     = 1'b0;
        i_tx_last      = 1'b0;
        i_out_ready    = 1'b1;
        void'($urandom(32'h50d3ef22));
        cycle_limit = 40 * table_bytes() + 200;
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        @(negedge i_clk);
        check_value("o_rx_valid", 32'(o_rx_valid), 32'd0);
        check_value("o_out_valid", 32'(o_out_valid), 32'd0);
        check_value("o_out_last", 32'(o_out_last), 32'd0);
        check_value("o_tx_hdr_ready", 32'(o_tx_hdr_ready), 32'd1);
        check_value("o_in_ready", 32'(o_in_ready), 32'd1);
        check_value("o_led", 32'(o_led), 32'd0);
        check_digits(32'h0);
        @(posedge i_clk);
        #1;

        // receive and transmit of a row run side by side
        for (idx = 0; idx < NUM_TESTS; idx++) begin
            bp_mode = TESTS[idx].bp;
            fork
                send_rx_dgram(TESTS[idx]);
                send_tx_dgram(TESTS[idx].tx_len);
            join
        end
        bp_mode = 1'b0;

        while (rx_exp.size() != 0 || tx_exp.size() != 0 || led_pending) begin
            @(posedge i_clk);
            #1;
        end
        @(negedge i_clk);
        check_value("o_rx_valid", 32'(o_rx_valid), 32'd0);
        check_value("o_out_valid", 32'(o_out_valid), 32'd0);
        check_value("o_tx_hdr_ready", 32'(o_tx_hdr_ready), 32'd1);
        check_digits(DEST_IP);
        if (!stall_seen) begin
            stop_with_failure("receive FIFO never filled enough to stall the input");
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
